// File: hdl/afu_pkg.sv
`default_nettype none

package afu_pkg;

	// --------------------------------------------------------------------------
	// widths
	// --------------------------------------------------------------------------
	typedef logic [57:0]  line_addr_t;
	typedef logic [511:0] line_data_t;
	// one bit wider than the read index so that 64 fits
	typedef logic [6:0]   batch_size_t;
	typedef logic [7:0]   buf_idx_t;

	// --------------------------------------------------------------------------
	// batch geometry and host memory layout
	// --------------------------------------------------------------------------
	localparam int LINES_PER_READ = 4;
	localparam int MAX_READS      = 64;
	localparam int BUF_LINES      = 256;

	// handshake line sits just below the input region
	localparam line_addr_t HAND_OFFSET  = 58'd50348031;
	localparam line_addr_t INPUT_OFFSET = 58'd50348032;

	// handshake line fields
	localparam int TAG0_BIT  = 480;
	localparam int TAG1_BIT  = 482;
	localparam int BATCH_LSB = 448;

	// write record fields
	localparam int          FENCE_BIT = 511;
	localparam logic [31:0] DONE_CODE = 32'd16;

	// --------------------------------------------------------------------------
	// records
	// --------------------------------------------------------------------------
	typedef struct packed {
		line_addr_t k;
		line_addr_t l;
	} rd_pair_t;

	typedef struct packed {
		line_addr_t addr;
		line_data_t data;
	} wr_rec_t;

	typedef struct packed {
		line_data_t k;
		line_data_t l;
	} line_pair_t;

	typedef enum logic [2:0] {
		IDLE,
		POLL_REQ,
		POLL_WAIT,
		LOAD,
		OUTPUT,
		FENCE_1,
		DONE_REC,
		FENCE_2
	} job_state_t;

endpackage

`default_nettype wire

// File: hdl/rx_pair_join.sv
`default_nettype none

module rx_pair_join import afu_pkg::*; (
	input  wire             CLK_200M,
	input  wire             reset_n,
	input  wire             rx_valid,
	input  wire line_data_t rx_data,
	output logic            pair_valid,
	output line_pair_t      pair
);

	// low while waiting for the k half of a pair
	logic       parity;
	line_data_t k_hold;

	// control
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			parity     <= 1'b0;
			pair_valid <= 1'b0;
		end else begin
			pair_valid <= rx_valid && parity;
			// toggles on every response, never cleared between jobs
			if (rx_valid) begin
				parity <= !parity;
			end
		end
	end

	// payload
	always_ff @(posedge CLK_200M) begin
		if (rx_valid) begin
			if (!parity) begin
				k_hold <= rx_data;
			end else begin
				pair.k <= k_hold;
				pair.l <= rx_data;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/read_buffer.sv
`default_nettype none

module read_buffer import afu_pkg::*; (
	input  wire             CLK_200M,
	input  wire             wr_en,
	input  wire buf_idx_t   wr_idx,
	input  wire line_data_t wr_data,
	input  wire             rd_en,
	input  wire buf_idx_t   rd_idx,
	output line_data_t      rd_data
);

	// one batch of read lines
	line_data_t mem [BUF_LINES];

	// write port
	always_ff @(posedge CLK_200M) begin
		if (wr_en) begin
			mem[wr_idx] <= wr_data;
		end
	end

	// registered read, data one cycle after rd_en
	always_ff @(posedge CLK_200M) begin
		if (rd_en) begin
			rd_data <= mem[rd_idx];
		end
	end

endmodule

`default_nettype wire

// File: hdl/job_ctrl.sv
`default_nettype none

module job_ctrl import afu_pkg::*; (
	input  wire             CLK_200M,
	input  wire             reset_n,
	input  wire             start,
	input  wire             stall,
	input  wire line_addr_t src_ptr,
	input  wire line_addr_t dst_ptr,
	input  wire             req_ready,
	output logic            req_valid,
	output rd_pair_t        req,
	input  wire             pair_valid,
	input  wire line_pair_t pair,
	output logic            buf_wr_en,
	output buf_idx_t        buf_wr_idx,
	output line_data_t      buf_wr_data,
	output logic            buf_rd_en,
	output buf_idx_t        buf_rd_idx,
	input  wire line_data_t buf_rd_data,
	output logic            wr_strobe,
	output wr_rec_t         wr_rec
);

	job_state_t  state;
	logic        polling_tag;
	batch_size_t batch_size;
	batch_size_t batch_field;
	logic        tag_hit;

	// line counters, one bit wider than the buffer index
	logic [8:0]  line_total;
	logic [8:0]  issue_cnt;
	logic [8:0]  load_cnt;
	logic [8:0]  out_cnt;

	// buffer read in flight, and the line it belongs to
	logic        rd_pend;
	buf_idx_t    pend_idx;

	line_addr_t  hand_addr;
	line_addr_t  input_base;
	line_addr_t  load_addr;

	// --------------------------------------------------------------------------
	// addresses and handshake decode
	// --------------------------------------------------------------------------
	assign hand_addr  = src_ptr + HAND_OFFSET;
	assign input_base = src_ptr + INPUT_OFFSET;
	assign load_addr  = input_base + line_addr_t'(issue_cnt);
	assign line_total = 9'(batch_size) * 9'(LINES_PER_READ);

	// the handshake fields are taken from the l half
	assign batch_field = pair.l[BATCH_LSB +: $bits(batch_size_t)];
	assign tag_hit     = polling_tag ? pair.l[TAG1_BIT] : pair.l[TAG0_BIT];

	// --------------------------------------------------------------------------
	// read requests, both halves of a pair carry the same address
	// --------------------------------------------------------------------------
	always_comb begin
		req_valid = 1'b0;
		req.k     = hand_addr;
		req.l     = hand_addr;
		case (state)
			POLL_REQ: begin
				req_valid = req_ready && !stall;
			end
			LOAD: begin
				req_valid = req_ready && !stall && (issue_cnt < line_total);
				req.k     = load_addr;
				req.l     = load_addr;
			end
			default: begin
			end
		endcase
	end

	// buffer ports
	assign buf_wr_en   = (state == LOAD) && pair_valid;
	assign buf_wr_idx  = load_cnt[7:0];
	assign buf_wr_data = pair.k;
	assign buf_rd_en   = (state == OUTPUT) && !stall && (out_cnt < line_total);
	assign buf_rd_idx  = out_cnt[7:0];

	// --------------------------------------------------------------------------
	// write records
	// --------------------------------------------------------------------------
	always_comb begin
		wr_strobe   = 1'b0;
		wr_rec.addr = '0;
		wr_rec.data = '0;
		case (state)
			OUTPUT: begin
				// lines go back out unchanged
				wr_strobe   = rd_pend;
				wr_rec.addr = dst_ptr + line_addr_t'(pend_idx);
				wr_rec.data = buf_rd_data;
			end
			FENCE_1, FENCE_2: begin
				wr_strobe              = !stall;
				wr_rec.data[FENCE_BIT] = 1'b1;
			end
			DONE_REC: begin
				wr_strobe            = !stall;
				wr_rec.addr          = hand_addr;
				wr_rec.data[511:480] = DONE_CODE;
			end
			default: begin
			end
		endcase
	end

	// --------------------------------------------------------------------------
	// job FSM
	// --------------------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			state       <= IDLE;
			polling_tag <= 1'b0;
			issue_cnt   <= '0;
			load_cnt    <= '0;
			out_cnt     <= '0;
			rd_pend     <= 1'b0;
		end else begin
			rd_pend <= buf_rd_en;
			case (state)
				IDLE: begin
					issue_cnt <= '0;
					load_cnt  <= '0;
					out_cnt   <= '0;
					if (start) begin
						state <= POLL_REQ;
					end
				end
				POLL_REQ: begin
					if (req_valid) begin
						state <= POLL_WAIT;
					end
				end
				POLL_WAIT: begin
					if (pair_valid) begin
						if (tag_hit) begin
							// tag only changes here, next job looks for the other bit
							polling_tag <= !polling_tag;
							state       <= LOAD;
						end else begin
							state <= POLL_REQ;
						end
					end
				end
				LOAD: begin
					if (req_valid) begin
						issue_cnt <= issue_cnt + 9'd1;
					end
					if (buf_wr_en) begin
						load_cnt <= load_cnt + 9'd1;
					end
					if (load_cnt == line_total) begin
						state <= OUTPUT;
					end
				end
				OUTPUT: begin
					if (buf_rd_en) begin
						out_cnt <= out_cnt + 9'd1;
					end
					// wait for the last buffer read to drain
					if ((out_cnt == line_total) && !rd_pend) begin
						state <= FENCE_1;
					end
				end
				FENCE_1: begin
					if (!stall) begin
						state <= DONE_REC;
					end
				end
				DONE_REC: begin
					if (!stall) begin
						state <= FENCE_2;
					end
				end
				FENCE_2: begin
					if (!stall) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// batch size latch, clamped to what the buffer holds
	always_ff @(posedge CLK_200M) begin
		if ((state == POLL_WAIT) && pair_valid && tag_hit) begin
			batch_size <= (batch_field > batch_size_t'(MAX_READS)) ?
				batch_size_t'(MAX_READS) : batch_field;
		end
		if (buf_rd_en) begin
			pend_idx <= out_cnt[7:0];
		end
	end

endmodule

`default_nettype wire

// File: hdl/host_tx.sv
`default_nettype none

module host_tx import afu_pkg::*; (
	input  wire             CLK_200M,
	input  wire             reset_n,
	input  wire             stall,
	input  wire             req_valid,
	input  wire rd_pair_t   req,
	output logic            req_ready,
	output logic            rd_valid,
	output line_addr_t      rd_addr,
	input  wire             wr_strobe,
	input  wire wr_rec_t    wr_rec,
	output logic            wr_valid,
	output logic            fence_valid,
	output line_addr_t      wr_addr,
	output line_data_t      wr_data
);

	// l half waiting for its slot
	logic       l_pending;
	line_addr_t l_addr;
	logic       accept;

	assign req_ready = !l_pending && !stall;
	assign accept    = req_valid && req_ready;

	// --------------------------------------------------------------------------
	// read request serializer, k then l
	// --------------------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			l_pending <= 1'b0;
			rd_valid  <= 1'b0;
		end else begin
			// a held l half leaves even under stall
			rd_valid  <= accept || l_pending;
			l_pending <= accept;
		end
	end

	always_ff @(posedge CLK_200M) begin
		if (accept) begin
			rd_addr <= req.k;
			l_addr  <= req.l;
		end else if (l_pending) begin
			rd_addr <= l_addr;
		end
	end

	// --------------------------------------------------------------------------
	// write channel
	// --------------------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			wr_valid    <= 1'b0;
			fence_valid <= 1'b0;
		end else begin
			wr_valid    <= wr_strobe;
			fence_valid <= wr_strobe && wr_rec.data[FENCE_BIT];
		end
	end

	always_ff @(posedge CLK_200M) begin
		if (wr_strobe) begin
			wr_addr <= wr_rec.addr;
			wr_data <= wr_rec.data;
		end
	end

endmodule

`default_nettype wire

// File: hdl/afu_core.sv
`default_nettype none

module afu_core import afu_pkg::*; (
	input  wire             CLK_200M,
	input  wire             reset_n,
	input  wire             start,
	input  wire line_addr_t src_ptr,
	input  wire line_addr_t dst_ptr,
	input  wire             rd_almostfull,
	input  wire             wr_almostfull,
	output logic            rd_valid,
	output line_addr_t      rd_addr,
	input  wire             rx_valid,
	input  wire line_data_t rx_data,
	output logic            wr_valid,
	output logic            fence_valid,
	output line_addr_t      wr_addr,
	output line_data_t      wr_data
);

	logic       start_q;
	logic       stall_q;

	logic       req_valid;
	logic       req_ready;
	rd_pair_t   req;
	logic       pair_valid;
	line_pair_t pair;
	logic       buf_wr_en;
	buf_idx_t   buf_wr_idx;
	line_data_t buf_wr_data;
	logic       buf_rd_en;
	buf_idx_t   buf_rd_idx;
	line_data_t buf_rd_data;
	logic       wr_strobe;
	wr_rec_t    wr_rec;

	// input registers, either almost-full stalls the whole engine
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			start_q <= 1'b0;
			stall_q <= 1'b0;
		end else begin
			start_q <= start;
			stall_q <= rd_almostfull || wr_almostfull;
		end
	end

	// --------------------------------------------------------------------------
	// datapath parts
	// --------------------------------------------------------------------------
	rx_pair_join u_rx_pair_join (
		.CLK_200M   (CLK_200M),
		.reset_n    (reset_n),
		.rx_valid   (rx_valid),
		.rx_data    (rx_data),
		.pair_valid (pair_valid),
		.pair       (pair)
	);

	read_buffer u_read_buffer (
		.CLK_200M (CLK_200M),
		.wr_en    (buf_wr_en),
		.wr_idx   (buf_wr_idx),
		.wr_data  (buf_wr_data),
		.rd_en    (buf_rd_en),
		.rd_idx   (buf_rd_idx),
		.rd_data  (buf_rd_data)
	);

	job_ctrl u_job_ctrl (
		.CLK_200M    (CLK_200M),
		.reset_n     (reset_n),
		.start       (start_q),
		.stall       (stall_q),
		.src_ptr     (src_ptr),
		.dst_ptr     (dst_ptr),
		.req_ready   (req_ready),
		.req_valid   (req_valid),
		.req         (req),
		.pair_valid  (pair_valid),
		.pair        (pair),
		.buf_wr_en   (buf_wr_en),
		.buf_wr_idx  (buf_wr_idx),
		.buf_wr_data (buf_wr_data),
		.buf_rd_en   (buf_rd_en),
		.buf_rd_idx  (buf_rd_idx),
		.buf_rd_data (buf_rd_data),
		.wr_strobe   (wr_strobe),
		.wr_rec      (wr_rec)
	);

	host_tx u_host_tx (
		.CLK_200M    (CLK_200M),
		.reset_n     (reset_n),
		.stall       (stall_q),
		.req_valid   (req_valid),
		.req         (req),
		.req_ready   (req_ready),
		.rd_valid    (rd_valid),
		.rd_addr     (rd_addr),
		.wr_strobe   (wr_strobe),
		.wr_rec      (wr_rec),
		.wr_valid    (wr_valid),
		.fence_valid (fence_valid),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data)
	);

endmodule

`default_nettype wire

// File: dv/afu_checker.sv
`default_nettype none

module afu_checker import afu_pkg::*; (
	input  wire             CLK_200M,
	input  wire             reset_n,
	input  wire             rd_valid,
	input  wire line_addr_t rd_addr,
	input  wire             rx_valid,
	input  wire line_data_t rx_data,
	input  wire             wr_valid,
	input  wire             fence_valid,
	input  wire line_addr_t wr_addr,
	input  wire line_data_t wr_data,
	input  wire line_addr_t src_ptr,
	input  wire line_addr_t dst_ptr,
	input  wire             rd_almostfull,
	input  wire             wr_almostfull,
	input  wire batch_size_t job_batch,
	input  wire [7:0]       job_polls,
	output int              jobs_done,
	output int              pass_count,
	output int              fail_count,
	output int              job_errs
);

	// read addresses still waiting for their response
	line_addr_t addr_q [$];
	// every line the host returned in the current job, by address
	line_data_t seen [line_addr_t];

	logic       in_load;
	logic       rd_half;
	line_addr_t k_addr;
	int         pair_idx;
	int         load_idx;
	int         wr_idx;
	int         af_cycles;
	int         af_writes;

	task automatic report_value(input string name, input line_data_t got, input line_data_t exp);
		$display("FAIL %s: got %0h, expected %0h", name, got, exp);
		job_errs++;
	endtask

	task automatic report_plain(input string msg);
		$display("error: %s", msg);
		job_errs++;
	endtask

	// ------------------------------------------------------------------------
	// sampled on the rising edge, DUT outputs are settled by then
	// ------------------------------------------------------------------------
	always @(posedge CLK_200M) begin
		line_addr_t hand;
		line_addr_t base;
		line_addr_t exp_addr;
		line_addr_t resp_addr;
		line_data_t exp_data;
		logic       exp_fence;
		int         total;
		if (!reset_n) begin
			in_load    = 1'b0;
			rd_half    = 1'b0;
			pair_idx   = 0;
			load_idx   = 0;
			wr_idx     = 0;
			job_errs   = 0;
			af_cycles  = 0;
			af_writes  = 0;
			jobs_done  <= 0;
			pass_count = 0;
			fail_count = 0;
		end else begin
			hand  = src_ptr + HAND_OFFSET;
			base  = src_ptr + INPUT_OFFSET;
			total = int'(job_batch) * LINES_PER_READ;
			if (rd_almostfull || wr_almostfull) begin
				af_cycles++;
			end else begin
				af_cycles = 0;
				af_writes = 0;
			end

			// responses come back in request order
			if (rx_valid) begin
				resp_addr       = addr_q.pop_front();
				seen[resp_addr] = rx_data;
			end

			if (rd_valid) begin
				addr_q.push_back(rd_addr);
				if (!rd_half) begin
					if (af_cycles > 2) begin
						report_plain("read pair started while almost-full was held");
					end
					exp_addr = in_load ? base + line_addr_t'(load_idx) : hand;
					if (in_load && (load_idx >= total)) begin
						report_plain("read issued beyond the end of the batch");
					end else if (rd_addr != exp_addr) begin
						report_value("rd_addr", line_data_t'(rd_addr), line_data_t'(exp_addr));
					end
					k_addr = rd_addr;
				end else begin
					// l half repeats the k address
					if (rd_addr != k_addr) begin
						report_value("rd_addr", line_data_t'(rd_addr), line_data_t'(k_addr));
					end
					if (in_load) begin
						load_idx++;
					end else begin
						pair_idx++;
						if (pair_idx > int'(job_polls)) begin
							in_load = 1'b1;
						end
					end
				end
				rd_half = !rd_half;
			end

			if (wr_valid) begin
				if (af_cycles >= 2) begin
					af_writes++;
					if (af_writes == 4) begin
						report_plain("more than three writes while almost-full was held");
					end
				end
				if (!in_load) begin
					report_plain("write seen while the engine was still polling");
				end else begin
					exp_data = '0;
					if (wr_idx < total) begin
						exp_addr = dst_ptr + line_addr_t'(wr_idx);
						if (seen.exists(base + line_addr_t'(wr_idx))) begin
							exp_data = seen[base + line_addr_t'(wr_idx)];
						end else begin
							report_plain("line written before it was read from the host");
						end
						exp_fence = exp_data[FENCE_BIT];
					end else if (wr_idx == total + 1) begin
						exp_addr              = hand;
						exp_data[511:480]     = DONE_CODE;
						exp_fence             = 1'b0;
					end else begin
						exp_addr            = '0;
						exp_data[FENCE_BIT] = 1'b1;
						exp_fence           = 1'b1;
					end
					if (wr_addr != exp_addr) begin
						report_value("wr_addr", line_data_t'(wr_addr), line_data_t'(exp_addr));
					end
					if (wr_data != exp_data) begin
						report_value("wr_data", wr_data, exp_data);
					end
					if (fence_valid != exp_fence) begin
						report_value("fence_valid", line_data_t'(fence_valid),
							line_data_t'(exp_fence));
					end

					// second fence closes the job
					if (wr_idx == total + 2) begin
						if (job_errs == 0) begin
							$display("job %0d passed: %0d polls, %0d lines", jobs_done,
								pair_idx, total);
							pass_count++;
						end else begin
							$display("job %0d failed with %0d errors", jobs_done, job_errs);
							fail_count++;
						end
						jobs_done <= jobs_done + 1;
						in_load  = 1'b0;
						pair_idx = 0;
						load_idx = 0;
						wr_idx   = 0;
						job_errs = 0;
						seen.delete();
					end else begin
						wr_idx++;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/tb_afu_core.sv
`default_nettype none

module tb_afu_core import afu_pkg::*; ();

	localparam int NUM_ROWS = 5;

	typedef struct packed {
		batch_size_t batch;
		logic        tag;
		logic [7:0]  polls;
		logic        af_rd;
		logic [15:0] af_start;
		logic [15:0] af_len;
	} job_row_t;

	logic        CLK_200M;
	logic        reset_n;
	logic        start;
	line_addr_t  src_ptr;
	line_addr_t  dst_ptr;
	logic        rd_almostfull;
	logic        wr_almostfull;
	logic        rd_valid;
	line_addr_t  rd_addr;
	logic        rx_valid;
	line_data_t  rx_data;
	logic        wr_valid;
	logic        fence_valid;
	line_addr_t  wr_addr;
	line_data_t  wr_data;

	batch_size_t job_batch;
	logic [7:0]  job_polls;
	int          jobs_done;
	int          pass_count;
	int          fail_count;
	int          job_errs;

	job_row_t    rows [NUM_ROWS];
	int          row_idx;

	// host memory and the in-order response queue
	line_data_t  host_mem [line_addr_t];
	line_data_t  resp_data_q [$];
	int          resp_due_q [$];
	int          cyc;
	int          last_due;
	int          seen_row;
	int          hand_reads;

	initial begin
		CLK_200M = 1'b0;
		forever #5 CLK_200M = !CLK_200M;
	end

	afu_core u_afu_core (
		.CLK_200M      (CLK_200M),
		.reset_n       (reset_n),
		.start         (start),
		.src_ptr       (src_ptr),
		.dst_ptr       (dst_ptr),
		.rd_almostfull (rd_almostfull),
		.wr_almostfull (wr_almostfull),
		.rd_valid      (rd_valid),
		.rd_addr       (rd_addr),
		.rx_valid      (rx_valid),
		.rx_data       (rx_data),
		.wr_valid      (wr_valid),
		.fence_valid   (fence_valid),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data)
	);

	afu_checker u_afu_checker (
		.CLK_200M      (CLK_200M),
		.reset_n       (reset_n),
		.rd_valid      (rd_valid),
		.rd_addr       (rd_addr),
		.rx_valid      (rx_valid),
		.rx_data       (rx_data),
		.wr_valid      (wr_valid),
		.fence_valid   (fence_valid),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.src_ptr       (src_ptr),
		.dst_ptr       (dst_ptr),
		.rd_almostfull (rd_almostfull),
		.wr_almostfull (wr_almostfull),
		.job_batch     (job_batch),
		.job_polls     (job_polls),
		.jobs_done     (jobs_done),
		.pass_count    (pass_count),
		.fail_count    (fail_count),
		.job_errs      (job_errs)
	);

	// ------------------------------------------------------------------------
	// host memory model
	// ------------------------------------------------------------------------
	function automatic line_data_t random_line();
		line_data_t d;
		for (int k = 0; k < 16; k++) begin
			d[k*32 +: 32] = $urandom;
		end
		return d;
	endfunction

	// handshake line as the host shows it on poll number poll
	function automatic line_data_t hand_line(input int poll);
		line_data_t d;
		d = '0;
		if (row_idx < NUM_ROWS) begin
			if (poll >= int'(rows[row_idx].polls)) begin
				d[rows[row_idx].tag ? TAG1_BIT : TAG0_BIT] = 1'b1;
				d[BATCH_LSB +: $bits(batch_size_t)]        = rows[row_idx].batch;
			end else begin
				// only the other tag bit, which must not start a job
				d[rows[row_idx].tag ? TAG0_BIT : TAG1_BIT] = 1'b1;
			end
		end
		return d;
	endfunction

	always @(posedge CLK_200M) begin
		line_data_t d;
		int         due;
		cyc++;
		if (row_idx != seen_row) begin
			seen_row   = row_idx;
			hand_reads = 0;
		end
		if (rd_valid) begin
			if (rd_addr == src_ptr + HAND_OFFSET) begin
				d = hand_line(hand_reads / 2);
				hand_reads++;
			end else if (host_mem.exists(rd_addr)) begin
				d = host_mem[rd_addr];
			end else begin
				d = {8{6'b0, rd_addr}};
			end
			due = cyc + int'($urandom_range(6, 1));
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			resp_data_q.push_back(d);
			resp_due_q.push_back(due);
		end
		#1;
		if ((resp_due_q.size() > 0) && (resp_due_q[0] <= cyc)) begin
			rx_valid = 1'b1;
			rx_data  = resp_data_q.pop_front();
			void'(resp_due_q.pop_front());
		end else begin
			rx_valid = 1'b0;
		end
	end

	task automatic hold_almostfull(input logic use_rd, input int wait_cycles, input int len);
		repeat (wait_cycles) @(posedge CLK_200M);
		#1;
		if (use_rd) begin
			rd_almostfull = 1'b1;
		end else begin
			wr_almostfull = 1'b1;
		end
		repeat (len) @(posedge CLK_200M);
		#1;
		rd_almostfull = 1'b0;
		wr_almostfull = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// job table and main sequence
	// ------------------------------------------------------------------------
	initial begin
		int limit;
		line_addr_t base;
		void'($urandom(5));
		reset_n       = 1'b0;
		start         = 1'b0;
		src_ptr       = 58'h1000;
		dst_ptr       = 58'h20_0000;
		rd_almostfull = 1'b0;
		wr_almostfull = 1'b0;
		rx_valid      = 1'b0;
		rx_data       = '0;
		row_idx       = 0;
		seen_row      = 0;
		hand_reads    = 0;
		cyc           = 0;
		last_due      = 0;

		// batch, tag, polls, almost-full on rd, window start, window length
		rows[0] = '{7'd2,  1'b0, 8'd0, 1'b0, 16'd0,   16'd0};
		rows[1] = '{7'd3,  1'b1, 8'd3, 1'b1, 16'd20,  16'd15};
		rows[2] = '{7'd0,  1'b0, 8'd1, 1'b0, 16'd0,   16'd0};
		rows[3] = '{7'd5,  1'b1, 8'd2, 1'b0, 16'd40,  16'd30};
		rows[4] = '{7'd64, 1'b0, 8'd1, 1'b1, 16'd300, 16'd40};
		job_batch = rows[0].batch;
		job_polls = rows[0].polls;

		limit = 1000;
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit += int'(rows[r].batch) * LINES_PER_READ * 40;
			limit += (int'(rows[r].polls) + 1) * 40 + int'(rows[r].af_len) + 200;
		end
		fork
			begin
				repeat (limit) @(posedge CLK_200M);
				$display("timeout: jobs still unfinished after %0d cycles", limit);
				$display("Regression failed");
				$finish;
			end
		join_none

		repeat (10) @(posedge CLK_200M);
		#1;
		reset_n = 1'b1;

		for (int r = 0; r < NUM_ROWS; r++) begin
			row_idx   = r;
			job_batch = rows[r].batch;
			job_polls = rows[r].polls;
			base      = src_ptr + INPUT_OFFSET;
			for (int i = 0; i < int'(rows[r].batch) * LINES_PER_READ; i++) begin
				host_mem[base + line_addr_t'(i)] = random_line();
			end
			if (rows[r].af_len != 0) begin
				fork
					hold_almostfull(rows[r].af_rd, int'(rows[r].af_start),
						int'(rows[r].af_len));
				join_none
			end
			start = 1'b1;
			while (jobs_done < r + 1) @(posedge CLK_200M);
			#1;
		end

		// no tag from here on, polling may go on harmlessly
		row_idx   = NUM_ROWS;
		job_polls = 8'hff;
		start     = 1'b0;
		repeat (20) @(posedge CLK_200M);
		$display("jobs passed %0d, jobs failed %0d, of %0d", pass_count, fail_count, NUM_ROWS);
		if ((fail_count == 0) && (pass_count == NUM_ROWS) && (job_errs == 0)) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
hdl/afu_pkg.sv
hdl/rx_pair_join.sv
hdl/read_buffer.sv
hdl/job_ctrl.sv
hdl/host_tx.sv
hdl/afu_core.sv
dv/afu_checker.sv
dv/tb_afu_core.sv

// File: Makefile
# Verilator simulation of the job engine

VERILATOR ?= verilator
TOP       ?= tb_afu_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Regression passed

.PHONY: sim clean

# build, run, and pass only when the pass message shows up on a line of its own
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
